// ==== verilog/mcpu_mem_cfg.svh ====
`ifndef MCPU_MEM_CFG_SVH
`define MCPU_MEM_CFG_SVH

// Number of 32-bit words in the data memory, addresses above it wrap
`define MCPU_DMEM_DEPTH 256

// Wait states before the data memory reports done
`define MCPU_DMEM_WAIT 2

// Datapath width of the core
`define MCPU_XLEN 32

`endif

// ==== verilog/mcpu_mem_pkg.sv ====
`include "mcpu_mem_cfg.svh"

package mcpu_mem_pkg;

	// Access type encoding
	// Bit 2 marks a store, bit 1 a word, bit 0 a half, neither of the two a byte
	typedef logic [2:0] mem_type_t;

	// Request as computed by the address stage
	// The access type field is called mtype since type is a reserved word
	typedef struct packed {
		logic [31:0]            paddr;
		logic [`MCPU_XLEN-1:0]  data;
		mem_type_t              mtype;
		logic [4:0]             rd_num;
		logic                   rd_we;
	} mem_req_t;

	// Result handed to writeback
	typedef struct packed {
		logic [`MCPU_XLEN-1:0]  data;
		logic [4:0]             rd_num;
		logic                   rd_we;
	} wb_t;

endpackage

// ==== verilog/dcache_if.sv ====
`timescale 1ns/1ps
`include "mcpu_mem_cfg.svh"

interface dcache_if;

	// Word address, byte write mask (zero for loads) and request strobe
	logic [29:0]            paddr;
	logic [3:0]             write;
	logic                   valid;
	logic [`MCPU_XLEN-1:0]  wdata;

	// Completion and read word from the memory
	logic                   done;
	logic [`MCPU_XLEN-1:0]  rdata;

	modport master (
		output paddr, write, valid, wdata,
		input  done, rdata
	);

	modport slave (
		input  paddr, write, valid, wdata,
		output done, rdata
	);

endinterface

// ==== verilog/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clkrst_core_clk,
	input  logic     arst_n,
	input  logic     load,
	input  payload_t in_data,
	input  logic     drain,
	output logic     readyin,
	output logic     valid,
	output payload_t out_data
);

	// A new item may enter when the slot is empty or is being emptied this cycle
	assign readyin = ~valid | drain;

	// Occupancy flag
	// A load in the same edge as a drain keeps the slot full with the new item
	always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= 1'b0;
		end else if (load) begin
			valid <= 1'b1;
		end else if (drain) begin
			valid <= 1'b0;
		end
	end

	// Payload only changes on a load
	always_ff @(posedge clkrst_core_clk) begin
		if (load) begin
			out_data <= in_data;
		end
	end

endmodule

// ==== verilog/stage_mem.sv ====
`timescale 1ns/1ps
`include "mcpu_mem_cfg.svh"

module stage_mem (
	input  logic                   clkrst_core_clk,
	input  logic                   arst_n,
	input  logic                   req_valid,
	input  mcpu_mem_pkg::mem_req_t req,
	input  logic                   wb_readyin,
	output logic                   progress,
	output logic                   readyout,
	output mcpu_mem_pkg::wb_t      wb,
	dcache_if.master               dc
);
	import mcpu_mem_pkg::*;

	mem_type_t             req_type;
	logic [3:0]            mask;
	logic [3:0]            mask_q;
	logic                  active;
	logic [15:0]           half_lane;
	logic [7:0]            byte_lane;
	logic [`MCPU_XLEN-1:0] load_data;

	assign req_type = req.mtype;

	// Byte lanes touched by a store, nothing for a load
	always_comb begin
		if (!req_type[2]) begin
			mask = 4'b0000;
		end else if (req_type[1]) begin
			mask = 4'b1111;
		end else if (req_type[0]) begin
			mask = req.paddr[1] ? 4'b1100 : 4'b0011;
		end else begin
			mask = 4'b0001 << req.paddr[1:0];
		end
	end

	// The memory access starts one cycle after the request lands and drops for
	// one cycle after each completion, so a back-to-back request restarts the
	// wait-state count in the memory
	always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			mask_q <= 4'b0000;
		end else begin
			active <= req_valid & ~progress;
			mask_q <= (req_valid & ~progress) ? mask : 4'b0000;
		end
	end

	assign dc.valid = active;
	assign dc.paddr = req.paddr[31:2];
	assign dc.write = mask_q;
	assign dc.wdata = req.data;

	// Pick the addressed lane of the read word
	assign half_lane = req.paddr[1] ? dc.rdata[31:16] : dc.rdata[15:0];
	assign byte_lane = dc.rdata[8*req.paddr[1:0] +: 8];

	// Loads land in the low bits, zero extended
	always_comb begin
		if (req_type[1]) begin
			load_data = dc.rdata;
		end else if (req_type[0]) begin
			load_data = `MCPU_XLEN'(half_lane);
		end else begin
			load_data = `MCPU_XLEN'(byte_lane);
		end
	end

	assign wb.data   = load_data;
	assign wb.rd_num = req.rd_num;
	assign wb.rd_we  = req.rd_we;

	// Result is ready once the memory reports done for the pending request
	assign readyout = req_valid & active & dc.done;
	assign progress = readyout & wb_readyin;

endmodule

// ==== verilog/dmem.sv ====
`timescale 1ns/1ps
`include "mcpu_mem_cfg.svh"

module dmem (
	input  logic     clkrst_core_clk,
	input  logic     arst_n,
	dcache_if.slave  dc
);

	localparam int DEPTH = `MCPU_DMEM_DEPTH;
	localparam int IDX_W = $clog2(DEPTH);
	localparam int CNT_W = (`MCPU_DMEM_WAIT > 0) ? $clog2(`MCPU_DMEM_WAIT + 1) : 1;

	logic [`MCPU_XLEN-1:0] mem [DEPTH];
	logic [IDX_W-1:0]      idx;
	logic [CNT_W-1:0]      count;

	// High word address bits are ignored, so the array wraps
	assign idx = dc.paddr[IDX_W-1:0];

	// Wait-state counter
	// It stops at the limit so done stays up while the master stalls
	always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (!dc.valid) begin
			count <= '0;
		end else if (!dc.done) begin
			count <= count + 1'b1;
		end
	end

	assign dc.done = dc.valid & (count == CNT_W'(`MCPU_DMEM_WAIT));

	// Read path is a plain combinational lookup
	assign dc.rdata = mem[idx];

	// Byte-enabled write on the completing edge
	// Rewriting the same bytes while the master stalls leaves the word unchanged
	always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (dc.valid && dc.done) begin
			for (int b = 0; b < 4; b++) begin
				if (dc.write[b]) begin
					mem[idx][8*b +: 8] <= dc.wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

// ==== verilog/mcpu_mem_top.sv ====
`timescale 1ns/1ps

module mcpu_mem_top (
	input  logic        clkrst_core_clk,
	input  logic        arst_n,
	input  logic        req_progress,
	input  logic [31:0] req_paddr,
	input  logic [31:0] req_data,
	input  logic [2:0]  req_type,
	input  logic [4:0]  req_rd_num,
	input  logic        req_rd_we,
	input  logic        wb_progress,
	output logic        req_readyin,
	output logic        wb_readyout,
	output logic [31:0] wb_data,
	output logic [4:0]  wb_rd_num,
	output logic        wb_rd_we
);
	import mcpu_mem_pkg::*;

	mem_req_t req_in;
	mem_req_t req_q;
	logic     req_valid;
	wb_t      wb_in;
	wb_t      wb_q;
	logic     stage_progress;
	logic     wb_readyin;

	dcache_if dc ();

	// Bundle the request ports for the input register
	assign req_in.paddr  = req_paddr;
	assign req_in.data   = req_data;
	assign req_in.mtype  = req_type;
	assign req_in.rd_num = req_rd_num;
	assign req_in.rd_we  = req_rd_we;

	pipe_reg #(.payload_t(mem_req_t)) u_req (
		.clkrst_core_clk (clkrst_core_clk),
		.arst_n          (arst_n),
		.load            (req_progress),
		.in_data         (req_in),
		.drain           (stage_progress),
		.readyin         (req_readyin),
		.valid           (req_valid),
		.out_data        (req_q)
	);

	// The output register is the only consumer, so progress alone moves the result
	stage_mem u_stage (
		.clkrst_core_clk (clkrst_core_clk),
		.arst_n          (arst_n),
		.req_valid       (req_valid),
		.req             (req_q),
		.wb_readyin      (wb_readyin),
		.progress        (stage_progress),
		.readyout        (),
		.wb              (wb_in),
		.dc              (dc.master)
	);

	dmem u_dmem (
		.clkrst_core_clk (clkrst_core_clk),
		.arst_n          (arst_n),
		.dc              (dc.slave)
	);

	pipe_reg #(.payload_t(wb_t)) u_wb (
		.clkrst_core_clk (clkrst_core_clk),
		.arst_n          (arst_n),
		.load            (stage_progress),
		.in_data         (wb_in),
		.drain           (wb_progress),
		.readyin         (wb_readyin),
		.valid           (wb_readyout),
		.out_data        (wb_q)
	);

	// Writeback fields back out to plain ports
	assign wb_data   = wb_q.data;
	assign wb_rd_num = wb_q.rd_num;
	assign wb_rd_we  = wb_q.rd_we;

endmodule

// ==== sim/mem_checker.sv ====
`timescale 1ns/1ps
`include "mcpu_mem_cfg.svh"

module mem_checker (
	input  logic        clkrst_core_clk,
	input  logic        arst_n,
	input  logic        req_progress,
	input  logic [31:0] req_paddr,
	input  logic [31:0] req_data,
	input  logic [2:0]  req_type,
	input  logic [4:0]  req_rd_num,
	input  logic        req_rd_we,
	input  logic        wb_progress,
	input  logic        req_readyin,
	input  logic        wb_readyout,
	input  logic [31:0] wb_data,
	input  logic [4:0]  wb_rd_num,
	input  logic        wb_rd_we,
	input  logic        lat_en,
	output int          errors,
	output int          n_req,
	output int          n_res
);

	localparam int DEPTH = `MCPU_DMEM_DEPTH;
	localparam int LATENCY = `MCPU_DMEM_WAIT + 2;

	logic [7:0]  model [DEPTH*4];
	logic [31:0] q_data [$];
	logic [4:0]  q_rd [$];
	logic        q_we [$];
	logic        q_load [$];
	int          q_cyc [$];
	int          cyc;
	logic        fresh;
	logic        held;
	logic [37:0] held_res;

	initial begin
		for (int i = 0; i < DEPTH*4; i++) begin
			model[i] = 8'h00;
		end
		errors = 0;
		n_req = 0;
		n_res = 0;
		cyc = 0;
		fresh = 1'b1;
		held = 1'b0;
	end

	// Byte offset of the addressed word, wrapping at the memory size
	function automatic int base_of(input logic [31:0] paddr);
		return (int'(paddr[31:2]) % DEPTH) * 4;
	endfunction

	// Value a load returns, moved to the low bits and zero extended
	function automatic logic [31:0] model_load(input logic [31:0] paddr, input logic [2:0] mtype);
		int          b;
		logic [31:0] w;
		b = base_of(paddr);
		w = {model[b + 3], model[b + 2], model[b + 1], model[b]};
		if (mtype[1]) begin
			return w;
		end else if (mtype[0]) begin
			return paddr[1] ? {16'h0, w[31:16]} : {16'h0, w[15:0]};
		end
		return {24'h0, model[b + int'(paddr[1:0])]};
	endfunction

	// A word store writes all lanes, a half the pair picked by bit 1, a byte a single lane
	task automatic model_store(input logic [31:0] paddr, input logic [31:0] data,
			input logic [2:0] mtype);
		int         b;
		logic [3:0] lanes;
		b = base_of(paddr);
		lanes = 4'h0;
		if (mtype[1]) begin
			lanes = 4'hf;
		end else if (mtype[0]) begin
			lanes[{paddr[1], 1'b0} +: 2] = 2'b11;
		end else begin
			lanes[paddr[1:0]] = 1'b1;
		end
		for (int l = 0; l < 4; l++) begin
			if (lanes[l]) begin
				model[b + l] = data[8*l +: 8];
			end
		end
	endtask

	always @(posedge clkrst_core_clk) begin
		cyc++;
		if (!arst_n) begin
			if (cyc > 1 && (wb_readyout !== 1'b0 || req_readyin !== 1'b1)) begin
				$display("%0t: handshake outputs not idle during reset", $time);
				errors++;
			end
		end else begin
			// A result that was not taken must stay exactly as it was
			if (held && wb_readyout !== 1'b1) begin
				$display("%0t: result withdrawn before wb_progress took it", $time);
				errors++;
			end else if (held && {wb_data, wb_rd_num, wb_rd_we} !== held_res) begin
				$display("ERROR wb_data/wb_rd_num/wb_rd_we changed while stalled: expected %h, got %h",
					held_res, {wb_data, wb_rd_num, wb_rd_we});
				errors++;
			end
			if (req_progress) begin
				if (req_readyin !== 1'b1) begin
					$display("%0t: request pushed while req_readyin was low", $time);
					errors++;
				end
				q_data.push_back(model_load(req_paddr, req_type));
				q_rd.push_back(req_rd_num);
				q_we.push_back(req_rd_we);
				q_load.push_back(!req_type[2]);
				q_cyc.push_back(cyc);
				if (req_type[2]) begin
					model_store(req_paddr, req_data, req_type);
				end
				n_req++;
			end
			// wb_readyout is seen here one edge after it rises
			if (wb_readyout && fresh) begin
				if (q_cyc.size() == 0) begin
					$display("%0t: result offered with no request outstanding", $time);
					errors++;
				end else if (lat_en && cyc - q_cyc[0] - 1 != LATENCY) begin
					$display("ERROR wb_readyout latency: expected %h, got %h", LATENCY,
						cyc - q_cyc[0] - 1);
					errors++;
				end
			end
			if (wb_progress && wb_readyout && q_rd.size() > 0) begin
				if (q_load[0] && wb_data !== q_data[0]) begin
					$display("ERROR wb_data: expected %h, got %h", q_data[0], wb_data);
					errors++;
				end
				if (wb_rd_num !== q_rd[0]) begin
					$display("ERROR wb_rd_num: expected %h, got %h", q_rd[0], wb_rd_num);
					errors++;
				end
				if (wb_rd_we !== q_we[0]) begin
					$display("ERROR wb_rd_we: expected %h, got %h", q_we[0], wb_rd_we);
					errors++;
				end
				void'(q_data.pop_front());
				void'(q_rd.pop_front());
				void'(q_we.pop_front());
				void'(q_load.pop_front());
				void'(q_cyc.pop_front());
				n_res++;
			end else if (wb_progress) begin
				$display("%0t: wb_progress with no result to take", $time);
				errors++;
			end
			fresh = !wb_readyout || wb_progress;
			held = wb_readyout && !wb_progress;
			held_res = {wb_data, wb_rd_num, wb_rd_we};
		end
	end

endmodule

// ==== sim/tb_mem.sv ====
`timescale 1ns/1ps
`include "mcpu_mem_cfg.svh"

module tb_mem;

	localparam int N_REQ = 11 + 400;
	localparam int MAX_CYCLES = N_REQ * (`MCPU_DMEM_WAIT + 10) + 200;

	logic        clkrst_core_clk;
	logic        arst_n;
	logic        req_progress;
	logic [31:0] req_paddr;
	logic [31:0] req_data;
	logic [2:0]  req_type;
	logic [4:0]  req_rd_num;
	logic        req_rd_we;
	logic        wb_progress;
	logic        req_readyin;
	logic        wb_readyout;
	logic [31:0] wb_data;
	logic [4:0]  wb_rd_num;
	logic        wb_rd_we;
	logic        lat_en;
	logic        bp_en;
	logic [31:0] rng;
	int          sent;
	int          consumed;
	int          cycles;
	int          count_err;
	int          errors;
	int          n_req;
	int          n_res;

	mcpu_mem_top i_dut (.*);
	mem_checker u_check (.*);

	always #5 clkrst_core_clk = ~clkrst_core_clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// Advance one edge and serve the writeback side
	// With back-pressure on, a waiting result is taken only at random
	task automatic tick();
		@(posedge clkrst_core_clk);
		if (wb_progress && wb_readyout) begin
			consumed++;
		end
		if (wb_readyout && !wb_progress) begin
			rng = xorshift(rng);
			wb_progress <= ~bp_en | rng[3];
		end else begin
			wb_progress <= 1'b0;
		end
	endtask

	task automatic push_req(input logic [31:0] paddr, input logic [31:0] data,
			input logic [2:0] mtype, input logic [4:0] rd, input logic we);
		req_progress <= 1'b1;
		req_paddr    <= paddr;
		req_data     <= data;
		req_type     <= mtype;
		req_rd_num   <= rd;
		req_rd_we    <= we;
		sent++;
	endtask

	// One request with nothing else in flight, so its latency is exact
	task automatic send_one(input logic [31:0] paddr, input logic [31:0] data,
			input logic [2:0] mtype, input logic [4:0] rd);
		tick();
		while (!req_readyin || req_progress) begin
			tick();
		end
		push_req(paddr, data, mtype, rd, rd[0]);
		tick();
		req_progress <= 1'b0;
		while (consumed != sent) begin
			tick();
		end
	endtask

	initial begin
		clkrst_core_clk = 1'b0;
		arst_n = 1'b0;
		req_progress = 1'b0;
		req_paddr = '0;
		req_data = '0;
		req_type = '0;
		req_rd_num = '0;
		req_rd_we = 1'b0;
		wb_progress = 1'b0;
		lat_en = 1'b1;
		bp_en = 1'b0;
		rng = 32'he8a6a03d;
		sent = 0;
		consumed = 0;
		count_err = 0;
		repeat (16) @(posedge clkrst_core_clk);
		arst_n <= 1'b1;

		// Unwritten word, then word, byte and half stores each read back
		send_one(32'h0000_00a0, 32'h0000_0000, 3'b010, 5'd1);
		send_one(32'h0000_0010, 32'h1122_3344, 3'b110, 5'd2);
		send_one(32'h0000_0010, 32'h0000_0000, 3'b010, 5'd3);
		send_one(32'h0000_0011, 32'h0000_ab00, 3'b100, 5'd4);
		send_one(32'h0000_0010, 32'h0000_0000, 3'b010, 5'd5);
		send_one(32'h0000_0011, 32'h0000_0000, 3'b000, 5'd6);
		send_one(32'h0000_0012, 32'hbeef_0000, 3'b101, 5'd7);
		send_one(32'h0000_0012, 32'h0000_0000, 3'b001, 5'd8);
		send_one(32'h0000_0010, 32'h0000_0000, 3'b001, 5'd9);
		send_one(32'h0000_0013, 32'h0000_0000, 3'b000, 5'd10);
		send_one(32'h0000_0410, 32'h0000_0000, 3'b010, 5'd11);

		// Random traffic in a 16-word window and its alias one memory size up
		lat_en <= 1'b0;
		bp_en = 1'b1;
		while (consumed < N_REQ) begin
			tick();
			rng = xorshift(rng);
			if (sent < N_REQ && req_readyin && !req_progress && rng[31:30] != 2'b00) begin
				push_req(rng & 32'h0000_043f, xorshift(rng), rng[14:12], rng[20:16], rng[24]);
			end else begin
				req_progress <= 1'b0;
			end
		end
		repeat (10) tick();
		@(negedge clkrst_core_clk);
		if (n_req != N_REQ || n_res != N_REQ || consumed != N_REQ) begin
			$display("Result count %0d does not match request count %0d", n_res, n_req);
			count_err++;
		end
		$display("Summary: %0d requests, %0d results, %0d errors", n_req, n_res,
			errors + count_err);
		if (errors + count_err == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clkrst_core_clk);
			cycles++;
		end
		@(negedge clkrst_core_clk);
		$display("Timeout after %0d cycles with %0d of %0d results consumed", cycles,
			consumed, N_REQ);
		$display("Summary: %0d requests, %0d results, %0d errors", n_req, n_res, errors + 1);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/mcpu_mem_pkg.sv
verilog/dcache_if.sv
verilog/pipe_reg.sv
verilog/stage_mem.sv
verilog/dmem.sv
verilog/mcpu_mem_top.sv
sim/mem_checker.sv
sim/tb_mem.sv

// ==== Makefile ====
TOP = tb_mem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
